//--- sources.f
+incdir+common
common/rv_isa_pkg.sv
common/id_ctrl_pkg.sv
decode/inst_decoder.sv
hdl/reg_file.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/id_stage.sv
bench/id_stage_tb.sv

//--- bench/id_patterns.txt
# stim: mask inst pc v1 v2 es_v es_ld es_dest es_data ms_v ms_dest ms_data ws_v ws_dest ws_data
# exp:  alu src1 src2 imm rf_we mem_we mem_re size unsigned rd rs1_val rs2_val taken target stop
7 123450b7 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 2 1 12345000 1 0 0 0 0 1 0 0 0 0 0
7 fffff117 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 1 1 fffffffffffff000 1 0 0 0 0 2 0 0 0 0 0
17 100000ef 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 1 2 100 1 0 0 0 0 1 0 0 1 1100 0
1f 008280e7 1000 2000 3 0 0 0 0 0 0 0 0 0 0
0 1 2 8 1 0 0 0 0 1 2000 3 1 2008 0
1b 00b50863 1000 5 5 0 0 0 0 0 0 0 0 0 0
0 0 0 10 0 0 0 0 0 0 5 5 1 1010 0
1b 00b51863 1000 5 5 0 0 0 0 0 0 0 0 0 0
0 0 0 10 0 0 0 0 0 0 5 5 0 1010 0
1b 00b54863 1000 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0
0 0 0 10 0 0 0 0 0 0 ffffffffffffffff 1 1 1010 0
1b 00b55863 1000 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0
0 0 0 10 0 0 0 0 0 0 ffffffffffffffff 1 0 1010 0
1b 00b56863 1000 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0
0 0 0 10 0 0 0 0 0 0 ffffffffffffffff 1 0 1010 0
1b 00b57863 1000 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0
0 0 0 10 0 0 0 0 0 0 ffffffffffffffff 1 1 1010 0
27 ffc10183 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 fffffffffffffffc 1 0 1 0 0 3 0 0 0 0 0
27 00615203 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 6 1 0 1 1 1 4 0 0 0 0 0
27 00016283 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 0 1 0 1 2 1 5 0 0 0 0 0
27 00813303 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 8 1 0 1 3 0 6 0 0 0 0 0
23 fe713823 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 fffffffffffffff0 0 1 0 3 0 0 0 0 0 0 0
23 007100a3 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 1 0 1 0 0 0 0 0 0 0 0 0
7 fff10093 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 ffffffffffffffff 1 0 0 0 0 1 0 0 0 0 0
7 00513193 1000 0 0 0 0 0 0 0 0 0 0 0 0
3 0 1 5 1 0 0 0 0 3 0 0 0 0 0
7 43f15213 1000 0 0 0 0 0 0 0 0 0 0 0 0
9 0 1 43f 1 0 0 0 0 4 0 0 0 0 0
7 00311293 1000 0 0 0 0 0 0 0 0 0 0 0 0
7 0 1 3 1 0 0 0 0 5 0 0 0 0 0
5 40b50333 1000 0 0 0 0 0 0 0 0 0 0 0 0
1 0 0 0 1 0 0 0 0 6 0 0 0 0 0
5 40b553b3 1000 0 0 0 0 0 0 0 0 0 0 0 0
9 0 0 0 1 0 0 0 0 7 0 0 0 0 0
5 00b53433 1000 0 0 0 0 0 0 0 0 0 0 0 0
3 0 0 0 1 0 0 0 0 8 0 0 0 0 0
d 00b574b3 1000 f0 3c 0 0 0 0 0 0 0 0 0 0
4 0 0 0 1 0 0 0 0 9 f0 3c 0 0 0
d 00b50633 1000 aa bb 1 0 a e1 1 a 11 1 b 77
0 0 0 0 1 0 0 0 0 c e1 77 0 0 0
d 00b50633 1000 aa bb 0 0 0 0 1 b 22 1 b 33
0 0 0 0 1 0 0 0 0 c aa 22 0 0 0
d 00b00633 1000 aa bb 1 0 0 44 1 0 55 1 b 66
0 0 0 0 1 0 0 0 0 c 0 66 0 0 0
d 00b50633 1000 aa bb 1 0 b 99 1 b 88 1 a 77
0 0 0 0 1 0 0 0 0 c 77 99 0 0 0
0 00100073 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
0 023100b3 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
0 003100bb 1000 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 1

//--- bench/id_stage_tb.sv
// testbench for id_stage that runs bench/id_patterns.txt plus register and stall tests
`timescale 1ns/1ps
`include "rv_defines.svh"

module id_stage_tb
    import id_ctrl_pkg::*;
;

    logic                   clk;
    logic                   reset;
    logic                   fs_valid;
    logic [`INST_WD-1:0]    fs_inst;
    logic [`PC_WD-1:0]      fs_pc;
    logic                   es_allowin;
    logic                   wb_we;
    logic [`RF_ADDR_WD-1:0] wb_addr;
    logic [`XLEN-1:0]       wb_data;
    logic                   es_valid;
    logic                   es_is_load;
    logic [`RF_ADDR_WD-1:0] es_dest;
    logic [`XLEN-1:0]       es_data;
    logic                   ms_valid;
    logic [`RF_ADDR_WD-1:0] ms_dest;
    logic [`XLEN-1:0]       ms_data;
    logic                   ws_valid;
    logic [`RF_ADDR_WD-1:0] ws_dest;
    logic [`XLEN-1:0]       ws_data;
    logic                   ds_allowin;
    logic                   ds_to_es_valid;
    alu_op_e                alu_op;
    src1_sel_e              src1_sel;
    src2_sel_e              src2_sel;
    logic [`XLEN-1:0]       imm;
    logic                   rf_we;
    logic                   mem_we;
    logic                   mem_re;
    mem_size_e              mem_size;
    logic                   mem_unsigned;
    logic [`RF_ADDR_WD-1:0] rd;
    logic [`XLEN-1:0]       rs1_value;
    logic [`XLEN-1:0]       rs2_value;
    logic [`PC_WD-1:0]      pc;
    logic                   br_taken;
    logic [`PC_WD-1:0]      br_target;
    logic                   stop;

    logic [`XLEN-1:0] model [`RF_NUM];
    logic [15:0]      lfsr_state;
    logic [63:0]      stim [15];
    logic [63:0]      expv [15];

    id_stage dut (.*);

    always #5 clk = ~clk;

    // ------------------------------------------------------------------------
    // helpers
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output logic [63:0] w);
        w = '0;
        for (int k = 0; k < 64; k++) begin
            w = {w[62:0], lfsr_state[15]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic timed_out(input string what);
        $display("gave up waiting for %s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic wait_allowin();
        int n;
        n = 0;
        @(negedge clk);
        while (!ds_allowin) begin
            n++;
            if (n > 20) begin
                timed_out("ds_allowin");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (!ds_to_es_valid) begin
            n++;
            if (n > 20) begin
                timed_out("ds_to_es_valid");
            end
            @(negedge clk);
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [63:0] data);
        @(posedge clk);
        wb_we   <= 1'b1;
        wb_addr <= addr;
        wb_data <= data;
        if (addr != 0) begin
            model[addr] = data;
        end
    endtask

    task automatic end_writes();
        @(posedge clk);
        wb_we <= 1'b0;
    endtask

    // present one instruction for capture at the following edge
    task automatic issue(input logic [31:0] inst, input logic [63:0] addr);
        wait_allowin();
        @(posedge clk);
        fs_valid <= 1'b1;
        fs_inst  <= inst;
        fs_pc    <= addr;
        @(posedge clk);
        fs_valid <= 1'b0;
    endtask

    function automatic logic [31:0] add_inst(input logic [4:0] a, input logic [4:0] b);
        return {7'b0, b, a, 3'b000, 5'd0, 7'b0110011};
    endfunction

    task automatic next_data_line(input int fd, output string line, output bit ok);
        int n;
        ok = 1'b0;
        while (!ok && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != 8'h23) begin
                ok = 1'b1;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // one vector from the pattern file
    task automatic run_vector();
        logic [63:0] mask;
        logic [4:0]  ra;
        logic [4:0]  rb;
        mask = stim[0];
        ra   = stim[1][19:15];
        rb   = stim[1][24:20];
        write_reg(ra, stim[3]);
        write_reg(rb, stim[4]);
        end_writes();
        es_valid   <= stim[5][0];
        es_is_load <= stim[6][0];
        es_dest    <= stim[7][4:0];
        es_data    <= stim[8];
        ms_valid   <= stim[9][0];
        ms_dest    <= stim[10][4:0];
        ms_data    <= stim[11];
        ws_valid   <= stim[12][0];
        ws_dest    <= stim[13][4:0];
        ws_data    <= stim[14];
        issue(stim[1][31:0], stim[2]);
        wait_valid();
        if (mask[0]) begin
            check(alu_op, expv[0], "alu_op");
            check(src1_sel, expv[1], "src1_sel");
            check(src2_sel, expv[2], "src2_sel");
            check(rf_we, expv[4], "rf_we");
            check(mem_we, expv[5], "mem_we");
            check(mem_re, expv[6], "mem_re");
        end
        if (mask[1]) begin
            check(imm, expv[3], "imm");
        end
        if (mask[2]) begin
            check(rd, expv[9], "rd");
        end
        if (mask[3]) begin
            check(rs1_value, expv[10], "rs1_value");
            check(rs2_value, expv[11], "rs2_value");
        end
        if (mask[4]) begin
            check(br_target, expv[13], "br_target");
        end
        if (mask[5]) begin
            check(mem_size, expv[7], "mem_size");
            check(mem_unsigned, expv[8], "mem_unsigned");
        end
        check(br_taken, expv[12], "br_taken");
        check(stop, expv[14], "stop");
        check(pc, stim[2], "pc");
    endtask

    initial begin
        int          fd;
        int          n;
        int          count;
        bit          ok;
        string       line;
        logic [63:0] w;
        logic [4:0]  j;
        clk        = 1'b0;
        reset      = 1'b1;
        fs_valid   = 1'b0;
        fs_inst    = '0;
        fs_pc      = '0;
        es_allowin = 1'b1;
        wb_we      = 1'b0;
        wb_addr    = '0;
        wb_data    = '0;
        es_valid   = 1'b0;
        es_is_load = 1'b0;
        es_dest    = '0;
        es_data    = '0;
        ms_valid   = 1'b0;
        ms_dest    = '0;
        ms_data    = '0;
        ws_valid   = 1'b0;
        ws_dest    = '0;
        ws_data    = '0;
        lfsr_state = 16'd87;
        count      = 0;
        model[0]   = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check(ds_to_es_valid, 0, "ds_to_es_valid after reset");
        check(br_taken, 0, "br_taken after reset");
        check(stop, 0, "stop after reset");
        check(ds_allowin, 1, "ds_allowin after reset");

        // register file fill and read back
        for (int i = 1; i < `RF_NUM; i++) begin
            random_word(w);
            write_reg(i[4:0], w);
        end
        end_writes();
        for (int i = 1; i < `RF_NUM; i++) begin
            j = 5'((i * 7) % 32);
            issue(add_inst(i[4:0], j), 64'h200);
            wait_valid();
            check(rs1_value, model[i], "rs1_value from register file");
            check(rs2_value, model[j], "rs2_value from register file");
        end
        write_reg(5'd0, 64'hdead_beef_0bad_f00d);
        end_writes();
        issue(add_inst(5'd0, 5'd0), 64'h300);
        wait_valid();
        check(rs1_value, 0, "x0 on rs1");
        check(rs2_value, 0, "x0 on rs2");

        // load-use stall
        @(posedge clk);
        es_valid   <= 1'b1;
        es_is_load <= 1'b1;
        es_dest    <= 5'd5;
        issue(add_inst(5'd5, 5'd6), 64'h400);
        repeat (3) begin
            @(negedge clk);
            check(ds_to_es_valid, 0, "ds_to_es_valid during stall");
            check(ds_allowin, 0, "ds_allowin during stall");
        end
        @(posedge clk);
        es_valid   <= 1'b0;
        es_is_load <= 1'b0;
        wait_valid();
        check(ds_allowin, 1, "ds_allowin after stall");

        // back-pressure holds the stage
        wait_allowin();
        @(posedge clk);
        es_allowin <= 1'b0;
        fs_valid   <= 1'b1;
        fs_inst    <= 32'h1234_50b7;
        fs_pc      <= 64'h40;
        @(posedge clk);
        fs_inst <= 32'hfff1_0093;
        fs_pc   <= 64'h44;
        repeat (3) begin
            @(negedge clk);
            check(pc, 64'h40, "pc under back-pressure");
            check(imm, 64'h1234_5000, "imm under back-pressure");
            check(ds_allowin, 0, "ds_allowin under back-pressure");
            check(ds_to_es_valid, 1, "ds_to_es_valid under back-pressure");
        end
        @(posedge clk);
        es_allowin <= 1'b1;
        @(posedge clk);
        fs_valid <= 1'b0;
        @(negedge clk);
        check(pc, 64'h44, "pc after back-pressure");
        check(imm, 64'hffff_ffff_ffff_ffff, "imm after back-pressure");

        // ------------------------------------------------------------------------
        // pattern file holds a stimulus line then an expected line
        fd = $fopen("bench/id_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            $display("TEST FAIL");
            $fatal(1);
        end
        next_data_line(fd, line, ok);
        while (ok) begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        stim[0], stim[1], stim[2], stim[3], stim[4], stim[5], stim[6],
                        stim[7], stim[8], stim[9], stim[10], stim[11], stim[12],
                        stim[13], stim[14]);
            next_data_line(fd, line, ok);
            if (n != 15 || !ok) begin
                $display("pattern file has a broken stimulus line");
                $display("TEST FAIL");
                $fatal(1);
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        expv[0], expv[1], expv[2], expv[3], expv[4], expv[5], expv[6],
                        expv[7], expv[8], expv[9], expv[10], expv[11], expv[12],
                        expv[13], expv[14]);
            if (n != 15) begin
                $display("pattern file has a broken expected line");
                $display("TEST FAIL");
                $fatal(1);
            end
            run_vector();
            count++;
            next_data_line(fd, line, ok);
        end
        $fclose(fd);
        check(count, 31, "number of pattern vectors");

        // empty stage after the last vector, which raised stop
        repeat (2) @(negedge clk);
        check(ds_to_es_valid, 0, "ds_to_es_valid when empty");
        check(stop, 0, "stop when empty");

        // a drained jump must not redirect fetch
        issue(32'h1000_00ef, 64'h1000);
        wait_valid();
        check(br_taken, 1, "br_taken on jal");
        repeat (2) @(negedge clk);
        check(br_taken, 0, "br_taken when empty");
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- hdl/id_stage.sv
// instruction decode stage of the RV64 pipeline, sits between fetch and execute
`timescale 1ns/1ps
`include "rv_defines.svh"

module id_stage
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // fetch
    input  logic                   fs_valid,
    input  logic [`INST_WD-1:0]    fs_inst,
    input  logic [`PC_WD-1:0]      fs_pc,
    output logic                   ds_allowin,
    output logic                   br_taken,
    output logic [`PC_WD-1:0]      br_target,
    // write-back port
    input  logic                   wb_we,
    input  logic [`RF_ADDR_WD-1:0] wb_addr,
    input  logic [`XLEN-1:0]       wb_data,
    // bypass sources
    input  logic                   es_valid,
    input  logic                   es_is_load,
    input  logic [`RF_ADDR_WD-1:0] es_dest,
    input  logic [`XLEN-1:0]       es_data,
    input  logic                   ms_valid,
    input  logic [`RF_ADDR_WD-1:0] ms_dest,
    input  logic [`XLEN-1:0]       ms_data,
    input  logic                   ws_valid,
    input  logic [`RF_ADDR_WD-1:0] ws_dest,
    input  logic [`XLEN-1:0]       ws_data,
    // execute
    input  logic                   es_allowin,
    output logic                   ds_to_es_valid,
    output alu_op_e                alu_op,
    output src1_sel_e              src1_sel,
    output src2_sel_e              src2_sel,
    output logic [`XLEN-1:0]       imm,
    output logic                   rf_we,
    output logic                   mem_we,
    output logic                   mem_re,
    output mem_size_e              mem_size,
    output logic                   mem_unsigned,
    output logic [`RF_ADDR_WD-1:0] rd,
    output logic [`XLEN-1:0]       rs1_value,
    output logic [`XLEN-1:0]       rs2_value,
    output logic [`PC_WD-1:0]      pc,
    output logic                   stop
);

    logic                   ds_valid;
    logic                   ds_ready_go;
    logic [`INST_WD-1:0]    ds_inst;
    logic [`PC_WD-1:0]      ds_pc;
    logic [`RF_ADDR_WD-1:0] rs1;
    logic [`RF_ADDR_WD-1:0] rs2;
    logic [`XLEN-1:0]       rf_data1;
    logic [`XLEN-1:0]       rf_data2;
    logic                   load_use_stall;
    branch_funct3_e         branch_type;
    logic                   is_branch;
    logic                   is_jal;
    logic                   is_jalr;
    logic                   is_ebreak;
    logic                   is_invalid;
    logic                   bu_taken;

    // ------------------------------------------------------------------------
    // stage register and flow control
    assign ds_ready_go    = !load_use_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    assign pc       = ds_pc;
    assign br_taken = ds_valid && bu_taken;
    assign stop     = ds_valid && (is_ebreak || is_invalid);

    // ------------------------------------------------------------------------
    inst_decoder u_decoder (
        .inst         (ds_inst),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .alu_op       (alu_op),
        .src1_sel     (src1_sel),
        .src2_sel     (src2_sel),
        .imm          (imm),
        .rf_we        (rf_we),
        .mem_we       (mem_we),
        .mem_re       (mem_re),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned),
        .branch_type  (branch_type),
        .is_branch    (is_branch),
        .is_jal       (is_jal),
        .is_jalr      (is_jalr),
        .is_ebreak    (is_ebreak),
        .is_invalid   (is_invalid)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2)
    );

    operand_forward u_forward (
        .rs1            (rs1),
        .rs2            (rs2),
        .rf_data1       (rf_data1),
        .rf_data2       (rf_data2),
        .es_valid       (es_valid),
        .es_is_load     (es_is_load),
        .es_dest        (es_dest),
        .es_data        (es_data),
        .ms_valid       (ms_valid),
        .ms_dest        (ms_dest),
        .ms_data        (ms_data),
        .ws_valid       (ws_valid),
        .ws_dest        (ws_dest),
        .ws_data        (ws_data),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .load_use_stall (load_use_stall)
    );

    branch_unit u_branch (
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .pc          (ds_pc),
        .imm         (imm),
        .branch_type (branch_type),
        .is_branch   (is_branch),
        .is_jal      (is_jal),
        .is_jalr     (is_jalr),
        .taken       (bu_taken),
        .target      (br_target)
    );

endmodule

//--- hdl/branch_unit.sv
// branch condition and jump target resolution in decode, used by id_stage to redirect fetch
`timescale 1ns/1ps
`include "rv_defines.svh"

module branch_unit
    import rv_isa_pkg::*;
(
    input  logic [`XLEN-1:0]  rs1_value,
    input  logic [`XLEN-1:0]  rs2_value,
    input  logic [`PC_WD-1:0] pc,
    input  logic [`XLEN-1:0]  imm,
    input  branch_funct3_e    branch_type,
    input  logic              is_branch,
    input  logic              is_jal,
    input  logic              is_jalr,
    output logic              taken,
    output logic [`PC_WD-1:0] target
);

    logic [`XLEN:0]    diff;
    logic              eq;
    logic              lt;
    logic              ltu;
    logic              cond;
    logic [`PC_WD-1:0] base;

    // ------------------------------------------------------------------------
    // compare, single subtractor with borrow out
    assign diff = {1'b0, rs1_value} - {1'b0, rs2_value};
    assign eq   = diff[`XLEN-1:0] == '0;
    assign ltu  = diff[`XLEN];
    // signs differ: the negative one is smaller
    assign lt   = (rs1_value[`XLEN-1] != rs2_value[`XLEN-1]) ? rs1_value[`XLEN-1]
                                                             : diff[`XLEN-1];

    always_comb begin
        case (branch_type)
            BR_BEQ:  cond = eq;
            BR_BNE:  cond = !eq;
            BR_BLT:  cond = lt;
            BR_BGE:  cond = !lt;
            BR_BLTU: cond = ltu;
            BR_BGEU: cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    assign taken = is_jal || is_jalr || (is_branch && cond);

    // ------------------------------------------------------------------------
    // target
    assign base   = is_jalr ? rs1_value : pc;
    assign target = base + imm;

endmodule

//--- hdl/operand_forward.sv
// operand bypass from execute, memory and write-back with load-use detection, used by id_stage
`timescale 1ns/1ps
`include "rv_defines.svh"

module operand_forward (
    input  logic [`RF_ADDR_WD-1:0] rs1,
    input  logic [`RF_ADDR_WD-1:0] rs2,
    input  logic [`XLEN-1:0]       rf_data1,
    input  logic [`XLEN-1:0]       rf_data2,
    input  logic                   es_valid,
    input  logic                   es_is_load,
    input  logic [`RF_ADDR_WD-1:0] es_dest,
    input  logic [`XLEN-1:0]       es_data,
    input  logic                   ms_valid,
    input  logic [`RF_ADDR_WD-1:0] ms_dest,
    input  logic [`XLEN-1:0]       ms_data,
    input  logic                   ws_valid,
    input  logic [`RF_ADDR_WD-1:0] ws_dest,
    input  logic [`XLEN-1:0]       ws_data,
    output logic [`XLEN-1:0]       rs1_value,
    output logic [`XLEN-1:0]       rs2_value,
    output logic                   load_use_stall
);

    logic es_hit1;
    logic es_hit2;
    logic ms_hit1;
    logic ms_hit2;
    logic ws_hit1;
    logic ws_hit2;

    // x0 never matches
    function automatic logic hit(logic valid, logic [`RF_ADDR_WD-1:0] dest,
                                 logic [`RF_ADDR_WD-1:0] src);
        return valid && src != '0 && dest == src;
    endfunction

    assign es_hit1 = hit(es_valid, es_dest, rs1);
    assign es_hit2 = hit(es_valid, es_dest, rs2);
    assign ms_hit1 = hit(ms_valid, ms_dest, rs1);
    assign ms_hit2 = hit(ms_valid, ms_dest, rs2);
    assign ws_hit1 = hit(ws_valid, ws_dest, rs1);
    assign ws_hit2 = hit(ws_valid, ws_dest, rs2);

    // youngest producer wins
    assign rs1_value = es_hit1 ? es_data :
                       ms_hit1 ? ms_data :
                       ws_hit1 ? ws_data : rf_data1;
    assign rs2_value = es_hit2 ? es_data :
                       ms_hit2 ? ms_data :
                       ws_hit2 ? ws_data : rf_data2;

    // load data not ready until memory stage
    assign load_use_stall = es_is_load && (es_hit1 || es_hit2);

endmodule

//--- hdl/reg_file.sv
// 32 x 64 integer register file, two async read ports and one write port, used by id_stage
`timescale 1ns/1ps
`include "rv_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic [`RF_ADDR_WD-1:0] raddr1,
    input  logic [`RF_ADDR_WD-1:0] raddr2,
    input  logic                   we,
    input  logic [`RF_ADDR_WD-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2
);

    logic [`XLEN-1:0] regs [`RF_NUM];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- decode/inst_decoder.sv
// combinational RV64I decoder, instantiated by id_stage on the held instruction
`timescale 1ns/1ps
`include "rv_defines.svh"

module inst_decoder
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic [`INST_WD-1:0]    inst,
    output logic [`RF_ADDR_WD-1:0] rs1,
    output logic [`RF_ADDR_WD-1:0] rs2,
    output logic [`RF_ADDR_WD-1:0] rd,
    output alu_op_e                alu_op,
    output src1_sel_e              src1_sel,
    output src2_sel_e              src2_sel,
    output logic [`XLEN-1:0]       imm,
    output logic                   rf_we,
    output logic                   mem_we,
    output logic                   mem_re,
    output mem_size_e              mem_size,
    output logic                   mem_unsigned,
    output branch_funct3_e         branch_type,
    output logic                   is_branch,
    output logic                   is_jal,
    output logic                   is_jalr,
    output logic                   is_ebreak,
    output logic                   is_invalid
);

    opcode_e          opcode;
    alu_funct3_e      funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    // shared by OP and OP_IMM, alt picks sub/sra
    function automatic alu_op_e alu_from_funct3(alu_funct3_e f3, logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // fields and immediates
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = alu_funct3_e'(inst[F3_LSB +: 3]);
    assign funct7 = inst[F7_LSB +: 7];
    assign rd     = inst[RD_LSB +: `RF_ADDR_WD];
    assign rs1    = inst[RS1_LSB +: `RF_ADDR_WD];
    assign rs2    = inst[RS2_LSB +: `RF_ADDR_WD];

    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign branch_type  = branch_funct3_e'(inst[F3_LSB +: 3]);
    assign mem_size     = mem_size_e'(inst[F3_LSB +: 2]);
    assign mem_unsigned = mem_re && inst[F3_LSB + 2];

    // ------------------------------------------------------------------------
    // control
    always_comb begin
        alu_op     = ALU_ADD;
        src1_sel   = SRC1_RS1;
        src2_sel   = SRC2_RS2;
        imm        = imm_i;
        rf_we      = 1'b0;
        mem_we     = 1'b0;
        mem_re     = 1'b0;
        is_branch  = 1'b0;
        is_jal     = 1'b0;
        is_jalr    = 1'b0;
        is_ebreak  = 1'b0;
        is_invalid = 1'b0;
        case (opcode)
            OPC_LUI: begin
                rf_we    = 1'b1;
                src1_sel = SRC1_ZERO;
                src2_sel = SRC2_IMM;
                imm      = imm_u;
            end
            OPC_AUIPC: begin
                rf_we    = 1'b1;
                src1_sel = SRC1_PC;
                src2_sel = SRC2_IMM;
                imm      = imm_u;
            end
            OPC_JAL: begin
                rf_we    = 1'b1;
                src1_sel = SRC1_PC;
                src2_sel = SRC2_FOUR;
                imm      = imm_j;
                is_jal   = 1'b1;
            end
            OPC_JALR: begin
                rf_we      = 1'b1;
                src1_sel   = SRC1_PC;
                src2_sel   = SRC2_FOUR;
                is_jalr    = 1'b1;
                is_invalid = funct3 != F3_ADD_SUB;
            end
            OPC_BRANCH: begin
                imm        = imm_b;
                is_branch  = 1'b1;
                is_invalid = !(branch_type inside {BR_BEQ, BR_BNE, BR_BLT,
                                                   BR_BGE, BR_BLTU, BR_BGEU});
            end
            OPC_LOAD: begin
                rf_we      = 1'b1;
                mem_re     = 1'b1;
                src2_sel   = SRC2_IMM;
                // no unsigned doubleword load
                is_invalid = inst[F3_LSB +: 3] == 3'b111;
            end
            OPC_STORE: begin
                mem_we     = 1'b1;
                src2_sel   = SRC2_IMM;
                imm        = imm_s;
                is_invalid = inst[F3_LSB + 2];
            end
            OPC_OP_IMM: begin
                rf_we    = 1'b1;
                src2_sel = SRC2_IMM;
                alu_op   = alu_from_funct3(funct3, funct3 == F3_SRL_SRA && funct7[5]);
                if (funct3 == F3_SLL) begin
                    is_invalid = funct7[6:1] != FUNCT6_SHIFT_NORMAL;
                end else if (funct3 == F3_SRL_SRA) begin
                    is_invalid = funct7[6:1] != FUNCT6_SHIFT_NORMAL &&
                                 funct7[6:1] != FUNCT6_SHIFT_ALT;
                end
            end
            OPC_OP: begin
                rf_we  = 1'b1;
                alu_op = alu_from_funct3(funct3, funct7 == FUNCT7_ALT);
                // M extension (funct7 = 1) lands here as invalid
                is_invalid = !(funct7 == FUNCT7_NORMAL ||
                               funct7 == FUNCT7_ALT &&
                               (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
            end
            OPC_SYSTEM: begin
                is_ebreak  = inst == INST_EBREAK;
                is_invalid = !is_ebreak;
            end
            default: is_invalid = 1'b1;
        endcase
    end

endmodule

//--- common/id_ctrl_pkg.sv
// control-word enums that decode passes to execute, imported by the stage and testbench
package id_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_e;

    // first alu operand
    typedef enum logic [1:0] {
        SRC1_RS1  = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2
    } src1_sel_e;

    // second alu operand, FOUR gives the link address
    typedef enum logic [1:0] {
        SRC2_RS2  = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_FOUR = 2'd2
    } src2_sel_e;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE   = 2'd0,
        MEM_HALF   = 2'd1,
        MEM_WORD   = 2'd2,
        MEM_DOUBLE = 2'd3
    } mem_size_e;

endpackage

//--- common/rv_isa_pkg.sv
// RV64I encoding enums and field positions, imported by the decoder and branch logic
package rv_isa_pkg;

    // major opcodes kept by this core, W forms deliberately absent
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_funct3_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_funct3_e;

    // ------------------------------------------------------------------------
    // field lsb positions
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB  = 25;

    localparam logic [6:0] FUNCT7_NORMAL = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
    // immediate shifts on RV64 give bit 25 to shamt
    localparam logic [5:0] FUNCT6_SHIFT_NORMAL = 6'b000000;
    localparam logic [5:0] FUNCT6_SHIFT_ALT    = 6'b010000;

    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

endpackage

//--- common/rv_defines.svh
// width and count macros for the decode-stage RTL and its testbench, pulled in by `include
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path
`define XLEN        64
`define PC_WD       64
`define INST_WD     32

// register file
`define RF_NUM      32
`define RF_ADDR_WD  5

`endif
